/* compile.f */
src/cpu_pkg.sv
src/decoder.sv
src/regfile.sv
src/alu.sv
src/stage_reg.sv
src/hazard_unit.sv
src/cpu_top.sv
dv/tb_clock.sv
dv/tb_cpu.sv

/* Bender.yml */
package:
  name: mips_pipeline

sources:
  - src/cpu_pkg.sv
  - src/decoder.sv
  - src/regfile.sv
  - src/alu.sv
  - src/stage_reg.sv
  - src/hazard_unit.sv
  - src/cpu_top.sv
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/tb_cpu.sv

/* dv/tb_cpu.sv */
module tb_cpu import cpu_pkg::*; ();

    localparam int seed            = 55745;
    localparam int prog_len        = 200;
    localparam int imem_words      = prog_len + 2;     // self-jump and its delay slot
    localparam int watchdog_cycles = imem_words * 8 + 100;

    logic       clk;
    logic       reset;
    logic       inst_sram_en;
    logic [3:0] inst_sram_wen;
    word_t      inst_sram_addr;
    word_t      inst_sram_wdata;
    word_t      inst_sram_rdata;
    logic       data_sram_en;
    logic [3:0] data_sram_wen;
    word_t      data_sram_addr;
    word_t      data_sram_wdata;
    word_t      data_sram_rdata;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_wen;
    reg_idx_t   debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    word_t    imem [imem_words];
    word_t    dmem [256];
    word_t    wb_pc_q [$];
    reg_idx_t wb_num_q [$];
    word_t    wb_val_q [$];
    word_t    st_addr_q [$];
    word_t    st_data_q [$];
    int       seen_writes = 0;
    int       seen_stores = 0;

    tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    cpu_top dut_i (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_wen     (inst_sram_wen),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    function automatic word_t fill_word(int i);
        return (i * 32'h9e37_79b9) ^ 32'h0bad_f00d;
    endfunction

    function automatic word_t fetch_word(word_t addr);
        word_t off;
        off = addr - reset_vector;
        if (off < 32'(imem_words * 4)) begin
            return imem[off[31:2]];
        end else begin
            return '0;      // outside the program reads as nop
        end
    endfunction

    // mostly r0..r7 so that dependencies are frequent
    function automatic reg_idx_t any_reg();
        int r;
        r = $urandom_range(8, 0);
        return (r == 8) ? reg_idx_t'(31) : reg_idx_t'(r);
    endfunction

    function automatic logic [5:0] alu_funct();
        case ($urandom_range(7, 0))
            0:       return fn_addu;
            1:       return fn_subu;
            2:       return fn_and;
            3:       return fn_or;
            4:       return fn_xor;
            5:       return fn_nor;
            6:       return fn_slt;
            default: return fn_sltu;
        endcase
    endfunction

    function automatic logic [5:0] shift_funct();
        case ($urandom_range(2, 0))
            0:       return fn_sll;
            1:       return fn_srl;
            default: return fn_sra;
        endcase
    endfunction

    function automatic logic [5:0] imm_opcode();
        case ($urandom_range(5, 0))
            0:       return op_addiu;
            1:       return op_slti;
            2:       return op_sltiu;
            3:       return op_andi;
            4:       return op_ori;
            default: return op_xori;
        endcase
    endfunction

    // add, addi, lb and sb are outside the subset
    function automatic word_t dropped_inst(reg_idx_t rs, reg_idx_t rt);
        case ($urandom_range(3, 0))
            0:       return {op_special, rs, rt, any_reg(), 5'd0, 6'h20};
            1:       return {6'h08, rs, rt, 16'($urandom())};
            2:       return {6'h20, 5'd0, rt, 16'h0010};
            default: return {6'h28, 5'd0, rt, 16'h0010};
        endcase
    endfunction

    task automatic gen_program();
        int          kind;
        int          tgt;
        logic        prev_cti;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [7:0]  widx;
        logic [15:0] off;
        logic [15:0] boff;
        word_t       taddr;
        prev_cti = 1'b0;
        for (int i = 0; i < prog_len; i++) begin
            rs    = any_reg();
            rt    = any_reg();
            widx  = 8'($urandom_range(255, 0));
            off   = {($urandom_range(1, 0) == 1) ? 6'b10_0000 : 6'b0, widx, 2'b00};
            tgt   = $urandom_range((i + 12 < prog_len) ? i + 12 : prog_len, i + 2);
            boff  = 16'(tgt - i - 1);
            taddr = reset_vector + 32'(tgt) * 4;
            // no jump or branch in a delay slot or next to the end
            if (prev_cti || i > prog_len - 3) begin
                kind = $urandom_range(11, 0);
            end else begin
                kind = $urandom_range(15, 0);
            end
            case (kind)
                0, 1, 2, 3: imem[i] = {op_special, rs, rt, any_reg(), 5'd0, alu_funct()};
                4:      imem[i] = {op_special, 5'd0, rt, any_reg(), 5'($urandom()), shift_funct()};
                5, 6, 7: imem[i] = {imm_opcode(), rs, rt, 16'($urandom())};
                8:      imem[i] = {op_lui, 5'd0, rt, 16'($urandom())};
                9:      imem[i] = {op_lw, 5'd0, rt, off};
                10:     imem[i] = {op_sw, 5'd0, rt, off};
                11:     imem[i] = dropped_inst(rs, rt);
                12, 13: begin
                    imem[i] = {(kind == 12) ? op_beq : op_bne, rs,
                               ($urandom_range(3, 0) == 0) ? rs : rt, boff};
                end
                default: imem[i] = {(kind == 14) ? op_j : op_jal, taddr[27:2]};
            endcase
            prev_cti = kind >= 12;
        end
        taddr = reset_vector + 32'(prog_len) * 4;
        imem[prog_len]     = {op_j, taddr[27:2]};      // park here
        imem[prog_len + 1] = '0;
    endtask

    // instruction-level reference that steps one instruction at a time
    task automatic run_model();
        word_t    regs [32];
        word_t    ref_mem [256];
        word_t    inst;
        word_t    pc;
        word_t    a;
        word_t    b;
        word_t    sext;
        word_t    zext;
        word_t    res;
        word_t    addr;
        word_t    jaddr;
        int       idx;
        int       next;
        int       pend;
        int       tgt;
        logic     wr;
        reg_idx_t dst;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        for (int w = 0; w < 256; w++) begin
            ref_mem[w] = fill_word(w);
        end
        idx  = 0;
        pend = -1;
        while (idx != prog_len) begin
            inst  = imem[idx];
            pc    = reset_vector + 32'(idx) * 4;
            a     = regs[inst[25:21]];
            b     = regs[inst[20:16]];
            sext  = {{16{inst[15]}}, inst[15:0]};
            zext  = {16'h0, inst[15:0]};
            addr  = (a + sext) & phys_addr_mask;
            jaddr = {pc[31:28], inst[25:0], 2'b00};   // delay slot stays in the region
            wr    = 1'b1;
            dst   = inst[20:16];
            res   = '0;
            tgt   = -1;
            case (inst[31:26])
                op_special: begin
                    dst = inst[15:11];
                    case (inst[5:0])
                        fn_addu: res = a + b;
                        fn_subu: res = a - b;
                        fn_and:  res = a & b;
                        fn_or:   res = a | b;
                        fn_xor:  res = a ^ b;
                        fn_nor:  res = ~(a | b);
                        fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        fn_sltu: res = (a < b) ? 32'd1 : 32'd0;
                        fn_sll:  res = b << inst[10:6];
                        fn_srl:  res = b >> inst[10:6];
                        fn_sra:  res = $signed(b) >>> inst[10:6];
                        default: wr = 1'b0;
                    endcase
                end
                op_addiu: res = a + sext;
                op_slti:  res = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
                op_sltiu: res = (a < sext) ? 32'd1 : 32'd0;
                op_andi:  res = a & zext;
                op_ori:   res = a | zext;
                op_xori:  res = a ^ zext;
                op_lui:   res = {inst[15:0], 16'h0};
                op_lw:    res = ref_mem[addr[9:2]];
                op_sw: begin
                    wr = 1'b0;
                    ref_mem[addr[9:2]] = b;
                    st_addr_q.push_back(addr);
                    st_data_q.push_back(b);
                end
                op_beq, op_bne: begin
                    wr = 1'b0;
                    if ((a == b) == (inst[31:26] == op_beq)) begin
                        tgt = idx + 1 + int'($signed(sext));
                    end
                end
                op_j, op_jal: begin
                    wr  = inst[31:26] == op_jal;
                    dst = 5'd31;
                    res = pc + 32'd8;
                    tgt = int'((jaddr - reset_vector) >> 2);
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 5'd0) begin
                regs[dst] = res;
                wb_pc_q.push_back(pc);
                wb_num_q.push_back(dst);
                wb_val_q.push_back(res);
            end
            next = (pend >= 0) ? pend : idx + 1;    // delay slot runs first
            pend = tgt;
            idx  = next;
        end
    endtask

    task automatic stop_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic abort_run(string why);
        $display("%s", why);
        stop_run();
    endtask

    task automatic show_mismatch(string name, word_t got, word_t want);
        $display("** Error: %s is %h, expected %h", name, got, want);
        stop_run();
    endtask

    task automatic check_wb(word_t pc, reg_idx_t num, word_t val);
        if (debug_wb_pc !== pc) begin
            show_mismatch("debug_wb_pc", debug_wb_pc, pc);
        end else if (debug_wb_rf_wnum !== num) begin
            show_mismatch("debug_wb_rf_wnum", 32'(debug_wb_rf_wnum), 32'(num));
        end else if (debug_wb_rf_wdata !== val) begin
            show_mismatch("debug_wb_rf_wdata", debug_wb_rf_wdata, val);
        end
    endtask

    task automatic check_store(word_t addr, word_t data);
        if (data_sram_addr !== addr) begin
            show_mismatch("data_sram_addr", data_sram_addr, addr);
        end else if (data_sram_wdata !== data) begin
            show_mismatch("data_sram_wdata", data_sram_wdata, data);
        end
    endtask

    task automatic check_fetch_port(logic en, logic [3:0] wen, word_t wdata);
        if (inst_sram_en !== en) begin
            show_mismatch("inst_sram_en", 32'(inst_sram_en), 32'(en));
        end else if (inst_sram_wen !== wen) begin
            show_mismatch("inst_sram_wen", 32'(inst_sram_wen), 32'(wen));
        end else if (inst_sram_wdata !== wdata) begin
            show_mismatch("inst_sram_wdata", inst_sram_wdata, wdata);
        end
    endtask

    // memories answer one cycle after the request
    always @(posedge clk) begin
        inst_sram_rdata <= fetch_word(inst_sram_addr);
        if (data_sram_en === 1'b1) begin
            if (data_sram_wen == 4'hf) begin
                dmem[data_sram_addr[9:2]] <= data_sram_wdata;
            end
            data_sram_rdata <= dmem[data_sram_addr[9:2]];
        end
    end

    always @(negedge clk) begin
        if (reset === 1'b0) begin
            check_fetch_port(1'b1, 4'h0, '0);
            if (debug_wb_rf_wen == 4'hf) begin
                if (wb_pc_q.size() == 0) begin
                    abort_run("register write seen after the last expected one");
                end else begin
                    seen_writes++;
                    check_wb(wb_pc_q.pop_front(), wb_num_q.pop_front(), wb_val_q.pop_front());
                end
            end else if (debug_wb_rf_wen !== 4'h0) begin
                show_mismatch("debug_wb_rf_wen", 32'(debug_wb_rf_wen), 32'hf);
            end
            if (data_sram_en === 1'b1 && data_sram_wen == 4'hf) begin
                if (st_addr_q.size() == 0) begin
                    abort_run("store seen after the last expected one");
                end else begin
                    seen_stores++;
                    check_store(st_addr_q.pop_front(), st_data_q.pop_front());
                end
            end else if (data_sram_wen !== 4'h0) begin
                show_mismatch("data_sram_wen", 32'(data_sram_wen), 32'h0);
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        abort_run($sformatf("timeout after %0d cycles, program did not retire", watchdog_cycles));
    end

    initial begin
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        void'($urandom(seed));
        for (int w = 0; w < 256; w++) begin
            dmem[w] = fill_word(w);
        end
        gen_program();
        run_model();
        while (reset !== 1'b0) begin
            @(posedge clk);
        end
        while (wb_pc_q.size() != 0 || st_addr_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);     // parked on the self-jump so nothing more may retire
        $display("%0d register writes and %0d stores checked", seen_writes, seen_stores);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* dv/tb_clock.sv */
module tb_clock (
    output logic clk,
    output logic reset
);
    localparam int half_period  = 2;
    localparam int reset_cycles = 3;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;      // released on the edge, seen by the dut one cycle on
    end

endmodule

/* src/cpu_top.sv */
module cpu_top import cpu_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    output logic       inst_sram_en,
    output logic [3:0] inst_sram_wen,
    output word_t      inst_sram_addr,
    output word_t      inst_sram_wdata,
    input  word_t      inst_sram_rdata,

    output logic       data_sram_en,
    output logic [3:0] data_sram_wen,
    output word_t      data_sram_addr,
    output word_t      data_sram_wdata,
    input  word_t      data_sram_rdata,

    output word_t      debug_wb_pc,
    output logic [3:0] debug_wb_rf_wen,
    output reg_idx_t   debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);
    word_t    pc;
    word_t    id_pc;
    word_t    id_inst;
    word_t    id_inst_q;
    logic     id_held;
    reg_idx_t id_rs;
    reg_idx_t id_rt;
    word_t    rf_rs;
    word_t    rf_rt;
    word_t    br_rs;
    word_t    br_rt;
    alu_op_e  id_alu_op;
    logic     id_use_imm;
    word_t    id_imm;
    logic     id_rs_ren;
    logic     id_rt_ren;
    logic     id_regwen;
    reg_idx_t id_wreg;
    logic     id_load;
    logic     id_store;
    logic     id_link;
    logic     id_taken;
    logic     id_branch;
    word_t    id_target;
    logic     stall_front;
    logic     bubble_ex;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    fwd_sel_e br_fwd_a;
    fwd_sel_e br_fwd_b;
    id_ex_t   id_ex_d;
    id_ex_t   ex_q;
    ex_mem_t  ex_mem_d;
    ex_mem_t  mem_q;
    mem_wb_t  mem_wb_d;
    mem_wb_t  wb_q;
    word_t    ex_a;
    word_t    ex_b;
    word_t    ex_res;
    word_t    mem_fwd;
    word_t    wb_wdata;

    function automatic word_t pick(fwd_sel_e sel, word_t rf_val, word_t mem_val,
                                   word_t wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return rf_val;     // fwd_ex only shows up while stalled
        endcase
    endfunction

    // fetch
    assign inst_sram_en    = 1'b1;
    assign inst_sram_wen   = 4'b0;
    assign inst_sram_wdata = '0;
    assign inst_sram_addr  = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_vector;
        end else if (!stall_front) begin
            pc <= id_taken ? id_target : pc + 32'd4;
        end
    end

    // on a stall the sram moves on, so the decode word is kept here
    always_ff @(posedge clk) begin
        if (reset) begin
            id_pc     <= '0;
            id_inst_q <= '0;
            id_held   <= 1'b1;      // first slot after reset decodes as nop
        end else begin
            id_held <= stall_front;
            if (stall_front) begin
                id_inst_q <= id_inst;
            end else begin
                id_pc <= pc;
            end
        end
    end

    assign id_inst   = id_held ? id_inst_q : inst_sram_rdata;
    assign id_rs     = id_inst[25:21];
    assign id_rt     = id_inst[20:16];
    assign id_branch = id_inst[31:26] == op_beq || id_inst[31:26] == op_bne;

    regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .rs     (id_rs),
        .rt     (id_rt),
        .wen    (wb_q.regwen),
        .wreg   (wb_q.wreg),
        .wdata  (wb_wdata),
        .rs_val (rf_rs),
        .rt_val (rf_rt)
    );

    assign br_rs = pick(br_fwd_a, rf_rs, mem_fwd, wb_wdata);
    assign br_rt = pick(br_fwd_b, rf_rt, mem_fwd, wb_wdata);

    decoder u_decoder (
        .inst    (id_inst),
        .pc      (id_pc),
        .rs_val  (br_rs),
        .rt_val  (br_rt),
        .alu_op  (id_alu_op),
        .use_imm (id_use_imm),
        .imm     (id_imm),
        .rs_ren  (id_rs_ren),
        .rt_ren  (id_rt_ren),
        .regwen  (id_regwen),
        .wreg    (id_wreg),
        .load    (id_load),
        .store   (id_store),
        .link    (id_link),
        .taken   (id_taken),
        .target  (id_target)
    );

    hazard_unit u_hazard_unit (
        .id_rs       (id_rs),
        .id_rt       (id_rt),
        .id_rs_ren   (id_rs_ren),
        .id_rt_ren   (id_rt_ren),
        .id_branch   (id_branch),
        .ex_regwen   (ex_q.regwen),
        .ex_wreg     (ex_q.wreg),
        .ex_load     (ex_q.load),
        .mem_regwen  (mem_q.regwen),
        .mem_wreg    (mem_q.wreg),
        .mem_load    (mem_q.load),
        .exr_rs      (ex_q.rs),
        .exr_rt      (ex_q.rt),
        .wb_regwen   (wb_q.regwen),
        .wb_wreg     (wb_q.wreg),
        .stall_front (stall_front),
        .bubble_ex   (bubble_ex),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .br_fwd_a    (br_fwd_a),
        .br_fwd_b    (br_fwd_b)
    );

    assign id_ex_d = '{
        pc:      id_pc,
        a:       rf_rs,
        b:       rf_rt,
        imm:     id_imm,
        alu_op:  id_alu_op,
        use_imm: id_use_imm,
        sa:      id_inst[10:6],
        rs:      id_rs,
        rt:      id_rt,
        regwen:  id_regwen,
        wreg:    id_wreg,
        load:    id_load,
        store:   id_store,
        link:    id_link
    };

    stage_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk    (clk),
        .reset  (reset),
        .stall  (1'b0),
        .bubble (bubble_ex),
        .d      (id_ex_d),
        .q      (ex_q)
    );

    // execute
    assign ex_a = pick(fwd_a, ex_q.a, mem_fwd, wb_wdata);
    assign ex_b = pick(fwd_b, ex_q.b, mem_fwd, wb_wdata);

    alu u_alu (
        .a   (ex_a),
        .b   (ex_q.use_imm ? ex_q.imm : ex_b),
        .op  (ex_q.alu_op),
        .sa  (ex_q.sa),
        .res (ex_res)
    );

    assign ex_mem_d = '{
        pc:         ex_q.pc,
        result:     ex_res,
        store_data: ex_b,
        regwen:     ex_q.regwen,
        wreg:       ex_q.wreg,
        load:       ex_q.load,
        store:      ex_q.store,
        link:       ex_q.link
    };

    stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk    (clk),
        .reset  (reset),
        .stall  (1'b0),
        .bubble (1'b0),
        .d      (ex_mem_d),
        .q      (mem_q)
    );

    // memory
    assign data_sram_en    = mem_q.load || mem_q.store;
    assign data_sram_wen   = mem_q.store ? 4'hf : 4'h0;
    assign data_sram_addr  = mem_q.result & phys_addr_mask;
    assign data_sram_wdata = mem_q.store_data;
    assign mem_fwd         = mem_q.link ? mem_q.pc + 32'd8 : mem_q.result;

    assign mem_wb_d = '{
        pc:     mem_q.pc,
        result: mem_q.result,
        regwen: mem_q.regwen,
        wreg:   mem_q.wreg,
        load:   mem_q.load,
        link:   mem_q.link
    };

    stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk    (clk),
        .reset  (reset),
        .stall  (1'b0),
        .bubble (1'b0),
        .d      (mem_wb_d),
        .q      (wb_q)
    );

    // writeback
    assign wb_wdata = wb_q.link ? wb_q.pc + 32'd8 :    // jal return address
                      wb_q.load ? data_sram_rdata : wb_q.result;

    assign debug_wb_pc       = wb_q.pc;
    assign debug_wb_rf_wen   = {4{wb_q.regwen}};
    assign debug_wb_rf_wnum  = wb_q.wreg;
    assign debug_wb_rf_wdata = wb_wdata;

    // only full words reach the data port
    assert property (@(posedge clk) disable iff (reset)
        data_sram_en |-> data_sram_addr[1:0] == 2'b00);

    // every interlock resolves within two cycles
    assert property (@(posedge clk) disable iff (reset) not (stall_front [*3]));

endmodule

/* src/hazard_unit.sv */
module hazard_unit import cpu_pkg::*; (
    input  reg_idx_t id_rs,
    input  reg_idx_t id_rt,
    input  logic     id_rs_ren,
    input  logic     id_rt_ren,
    input  logic     id_branch,
    input  logic     ex_regwen,
    input  reg_idx_t ex_wreg,
    input  logic     ex_load,
    input  logic     mem_regwen,
    input  reg_idx_t mem_wreg,
    input  logic     mem_load,
    input  reg_idx_t exr_rs,
    input  reg_idx_t exr_rt,
    input  logic     wb_regwen,
    input  reg_idx_t wb_wreg,
    output logic     stall_front,
    output logic     bubble_ex,
    output fwd_sel_e fwd_a,
    output fwd_sel_e fwd_b,
    output fwd_sel_e br_fwd_a,
    output fwd_sel_e br_fwd_b
);
    logic ex_dep;
    logic mem_dep;

    // nearest stage still holding a write to src
    function automatic fwd_sel_e nearest(reg_idx_t src, logic from_ex);
        if (src == '0) begin
            return fwd_rf;
        end
        if (from_ex && ex_regwen && ex_wreg == src) begin
            return fwd_ex;
        end
        if (mem_regwen && mem_wreg == src) begin
            return fwd_mem;
        end
        if (wb_regwen && wb_wreg == src) begin
            return fwd_wb;
        end
        return fwd_rf;
    endfunction

    always_comb begin
        fwd_a    = nearest(exr_rs, 1'b0);
        fwd_b    = nearest(exr_rt, 1'b0);
        br_fwd_a = id_rs_ren ? nearest(id_rs, 1'b1) : fwd_rf;
        br_fwd_b = id_rt_ren ? nearest(id_rt, 1'b1) : fwd_rf;

        ex_dep  = br_fwd_a == fwd_ex || br_fwd_b == fwd_ex;
        mem_dep = mem_load && (br_fwd_a == fwd_mem || br_fwd_b == fwd_mem);

        // load-use, or a branch whose operand is not ready yet
        stall_front = (ex_dep && (ex_load || id_branch)) || (mem_dep && id_branch);
        bubble_ex   = stall_front;
    end

endmodule

/* src/stage_reg.sv */
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     stall,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);
    always_ff @(posedge clk) begin
        if (reset || bubble) begin
            q <= '0;        // all-zero payload is a nop
        end else if (!stall) begin
            q <= d;
        end
    end

    // a held stage cannot also take a bubble
    assert property (@(posedge clk) disable iff (reset) !(stall && bubble));

endmodule

/* src/alu.sv */
module alu import cpu_pkg::*; (
    input  word_t      a,
    input  word_t      b,
    input  alu_op_e    op,
    input  logic [4:0] sa,
    output word_t      res
);
    always_comb begin
        case (op)
            alu_add:  res = a + b;
            alu_sub:  res = a - b;
            alu_and:  res = a & b;
            alu_or:   res = a | b;
            alu_xor:  res = a ^ b;
            alu_nor:  res = ~(a | b);
            alu_slt:  res = {31'b0, $signed(a) < $signed(b)};
            alu_sltu: res = {31'b0, a < b};
            alu_sll:  res = b << sa;
            alu_srl:  res = b >> sa;
            alu_sra:  res = $signed(b) >>> sa;
            alu_lui:  res = {b[15:0], 16'b0};
            default:  res = a + b;
        endcase
    end

endmodule

/* src/regfile.sv */
module regfile import cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs,
    input  reg_idx_t rt,
    input  logic     wen,
    input  reg_idx_t wreg,
    input  word_t    wdata,
    output word_t    rs_val,
    output word_t    rt_val
);
    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wreg != '0) begin
            regs[wreg] <= wdata;
        end
    end

    // same-cycle writeback passes straight through
    assign rs_val = (rs == '0) ? '0 :
                    (wen && wreg == rs) ? wdata : regs[rs];
    assign rt_val = (rt == '0) ? '0 :
                    (wen && wreg == rt) ? wdata : regs[rt];

endmodule

/* src/decoder.sv */
module decoder import cpu_pkg::*; (
    input  word_t    inst,
    input  word_t    pc,
    input  word_t    rs_val,
    input  word_t    rt_val,
    output alu_op_e  alu_op,
    output logic     use_imm,
    output word_t    imm,
    output logic     rs_ren,
    output logic     rt_ren,
    output logic     regwen,
    output reg_idx_t wreg,
    output logic     load,
    output logic     store,
    output logic     link,
    output logic     taken,
    output word_t    target
);
    logic [5:0] op;
    logic [5:0] fn;
    word_t      imm_sext;
    word_t      imm_zext;
    word_t      ds_pc;

    assign op       = inst[31:26];
    assign fn       = inst[5:0];
    assign imm_sext = {{16{inst[15]}}, inst[15:0]};
    assign imm_zext = {16'b0, inst[15:0]};
    assign ds_pc    = pc + 32'd4;   // delay slot

    always_comb begin
        alu_op  = alu_add;
        use_imm = 1'b0;
        imm     = imm_sext;
        rs_ren  = 1'b0;
        rt_ren  = 1'b0;
        regwen  = 1'b0;
        wreg    = inst[15:11];
        load    = 1'b0;
        store   = 1'b0;
        link    = 1'b0;
        taken   = 1'b0;
        target  = ds_pc + {imm_sext[29:0], 2'b00};

        case (op)
            op_special: begin
                rs_ren = 1'b1;
                rt_ren = 1'b1;
                regwen = 1'b1;
                case (fn)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_nor:  alu_op = alu_nor;
                    fn_slt:  alu_op = alu_slt;
                    fn_sltu: alu_op = alu_sltu;
                    fn_sll:  alu_op = alu_sll;
                    fn_srl:  alu_op = alu_srl;
                    fn_sra:  alu_op = alu_sra;
                    default: begin
                        regwen = 1'b0;
                        rs_ren = 1'b0;
                        rt_ren = 1'b0;
                    end
                endcase
                if (fn == fn_sll || fn == fn_srl || fn == fn_sra) begin
                    rs_ren = 1'b0;      // shift by sa, rs unused
                end
            end
            op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui: begin
                use_imm = 1'b1;
                rs_ren  = op != op_lui;
                regwen  = 1'b1;
                wreg    = inst[20:16];
                if (op == op_andi || op == op_ori || op == op_xori || op == op_lui) begin
                    imm = imm_zext;
                end
                case (op)
                    op_addiu: alu_op = alu_add;
                    op_slti:  alu_op = alu_slt;
                    op_sltiu: alu_op = alu_sltu;
                    op_andi:  alu_op = alu_and;
                    op_ori:   alu_op = alu_or;
                    op_xori:  alu_op = alu_xor;
                    default:  alu_op = alu_lui;
                endcase
            end
            op_lw: begin
                use_imm = 1'b1;
                rs_ren  = 1'b1;
                regwen  = 1'b1;
                wreg    = inst[20:16];
                load    = 1'b1;
            end
            op_sw: begin
                use_imm = 1'b1;
                rs_ren  = 1'b1;
                rt_ren  = 1'b1;
                store   = 1'b1;
            end
            op_beq, op_bne: begin
                rs_ren = 1'b1;
                rt_ren = 1'b1;
                taken  = (rs_val == rt_val) ^ (op == op_bne);
            end
            op_j, op_jal: begin
                taken  = 1'b1;
                target = {ds_pc[31:28], inst[25:0], 2'b00};
                link   = op == op_jal;
                regwen = op == op_jal;
                wreg   = 5'd31;
            end
            default: ;      // anything else is a nop
        endcase

        if (wreg == '0) begin
            regwen = 1'b0;  // r0 never written
        end
    end

endmodule

/* src/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or,
        alu_xor, alu_nor, alu_slt, alu_sltu,
        alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    // where an operand comes from
    typedef enum logic [1:0] {
        fwd_rf, fwd_ex, fwd_mem, fwd_wb
    } fwd_sel_e;

    localparam word_t reset_vector   = 32'hbfc0_0000;
    localparam word_t phys_addr_mask = 32'h1fff_ffff;

    // primary opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // special function codes
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    typedef struct packed {
        word_t      pc;
        word_t      a;          // rs from register file
        word_t      b;          // rt from register file
        word_t      imm;
        alu_op_e    alu_op;
        logic       use_imm;
        logic [4:0] sa;
        reg_idx_t   rs;
        reg_idx_t   rt;
        logic       regwen;
        reg_idx_t   wreg;
        logic       load;
        logic       store;
        logic       link;
    } id_ex_t;

    typedef struct packed {
        word_t    pc;
        word_t    result;
        word_t    store_data;
        logic     regwen;
        reg_idx_t wreg;
        logic     load;
        logic     store;
        logic     link;
    } ex_mem_t;

    typedef struct packed {
        word_t    pc;
        word_t    result;
        logic     regwen;
        reg_idx_t wreg;
        logic     load;
        logic     link;
    } mem_wb_t;

endpackage
